//--- Makefile
TOP = tb_tracer

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f verilog.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tb/tb_tracer.sv
`timescale 1ns/1ns

module tb_tracer import tracer_pkg::*; ();

    typedef struct packed {
        logic [7:0] op;
        int         a0;
        int         a1;
        int         a2;
        int         a3;
    } cmd_t;

    logic    s_axi_aclk;
    logic    s_axi_aresetn;
    pixel_t  pixel_in;
    pixel_t  pixel_out;
    logic    load_center;
    logic    load_contour;
    logic    contour_data;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;

    cmd_t    cmds [$];
    string   test_names [$];
    string   test_name;
    bit      test_open;
    int      test_errors;
    int      tests_passed;
    int      tests_failed;
    int      setup_errors;
    longint  watchdog_ns;
    logic    watchdog_armed;

    tracer_element_core tracer_element_core_inst (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .pixel_in      (pixel_in),
        .pixel_out     (pixel_out),
        .load_center   (load_center),
        .load_contour  (load_contour),
        .contour_data  (contour_data),
        .wb_req        (wb_req),
        .wb_rsp        (wb_rsp)
    );

    initial begin
        s_axi_aclk = 1'b0;
        forever #50 s_axi_aclk = ~s_axi_aclk;
    end

    initial begin
        wait (watchdog_armed);
        #(watchdog_ns);
        $display("Timeout: stimulus still running after %0d ns", watchdog_ns);
        $display("Regression failed");
        $finish;
    end

    //////////////////////////////////////////////////
    // Checks and reporting
    //////////////////////////////////////////////////

    task automatic check_acc(input int adr, input acc_t expected, input acc_t actual);
        if (actual !== expected) begin
            $display("mismatch in %s: acc[%0d] expected %0d actual %0d",
                     test_name, adr, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_pixel(input pixel_t expected, input pixel_t actual);
        if (actual !== expected) begin
            $display("mismatch in %s: pixel_out expected %h actual %h",
                     test_name, expected, actual);
            test_errors++;
        end
    endtask

    // Failures outside any test still fail the run
    task automatic note_failure(input string what);
        $display("%s: %s", test_name, what);
        if (test_open) begin
            test_errors++;
        end else begin
            setup_errors++;
        end
    endtask

    task automatic close_test();
        if (test_open) begin
            if (test_errors == 0) begin
                tests_passed++;
                $display("test %s: ok", test_name);
            end else begin
                tests_failed++;
                $display("test %s: %0d errors", test_name, test_errors);
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    task automatic apply_reset();
        @(negedge s_axi_aclk);
        s_axi_aresetn = 1'b0;
        repeat (16) @(negedge s_axi_aclk);
        s_axi_aresetn = 1'b1;
    endtask

    // Code 0 all zeros, 1 all ones, 2 odd raster positions
    task automatic load_mask(input int code);
        int i;
        if (code < 0) begin
            note_failure("unknown contour mask code in stimulus file");
            return;
        end
        for (i = 0; i < WINDOW_AREA; i++) begin
            @(negedge s_axi_aclk);
            load_contour = 1'b1;
            contour_data = (code == 1) || (code == 2 && i % 2 == 1);
        end
        @(negedge s_axi_aclk);
        load_contour = 1'b0;
        contour_data = 1'b0;
    endtask

    // Centre beat is not valid, so no element counts it
    task automatic load_center_at(input int row, input int col);
        @(negedge s_axi_aclk);
        pixel_in     = '0;
        pixel_in.row = ROW_W'(row);
        pixel_in.col = COL_W'(col);
        load_center  = 1'b1;
        @(negedge s_axi_aclk);
        pixel_in    = '0;
        load_center = 1'b0;
        @(negedge s_axi_aclk);
    endtask

    task automatic send_frame(input int r0, input int c0, input int r1, input int c1);
        int r;
        int c;
        for (r = r0; r <= r1; r++) begin
            for (c = c0; c <= c1; c++) begin
                @(negedge s_axi_aclk);
                pixel_in.valid = 1'b1;
                pixel_in.row   = ROW_W'(r);
                pixel_in.col   = COL_W'(c);
                pixel_in.data  = PIX_W'((r + 2 * c) % 256);
            end
        end
        @(negedge s_axi_aclk);
        pixel_in = '0;
        // Last beat lands two edges later
        repeat (2) @(negedge s_axi_aclk);
    endtask

    task automatic send_pixel_checked(input int row, input int col, input int data);
        pixel_t beat;
        beat.valid = 1'b1;
        beat.row   = ROW_W'(row);
        beat.col   = COL_W'(col);
        beat.data  = PIX_W'(data);
        @(negedge s_axi_aclk);
        pixel_in = beat;
        @(negedge s_axi_aclk);
        check_pixel(beat, pixel_out);
        pixel_in = '0;
    endtask

    task automatic wb_access(input logic write, input int adr, output acc_t dat,
                             output bit acked);
        int wait_cycles;
        acked       = 1'b0;
        dat         = '0;
        wait_cycles = 0;
        @(negedge s_axi_aclk);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = write;
        wb_req.adr = SEL_W'(adr);
        while (!acked && wait_cycles < 4) begin
            @(negedge s_axi_aclk);
            wait_cycles++;
            if (wb_rsp.ack) begin
                acked = 1'b1;
                dat   = wb_rsp.dat;
            end
        end
        wb_req = '0;
        if (!acked) begin
            note_failure($sformatf("no Wishbone acknowledge for address %0d within 4 cycles",
                                   adr));
        end
        @(negedge s_axi_aclk);
    endtask

    //////////////////////////////////////////////////
    // Command file
    //////////////////////////////////////////////////

    task automatic read_commands();
        int    fd;
        int    n;
        int    a0;
        int    a1;
        int    a2;
        int    a3;
        string line;
        string word;
        string text;
        cmd_t  cmd;
        fd = $fopen("tb/tracer_input.txt", "r");
        if (fd == 0) begin
            $display("Cannot open stimulus file tb/tracer_input.txt");
            setup_errors++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            cmd  = '0;
            word = "";
            n    = $sscanf(line, "%s", word);
            if (n < 1 || word[0] == "#") begin
                continue;
            end
            cmd.op = word[0];
            if (word == "T" || word == "M") begin
                n = $sscanf(line, "%s %s", word, text);
                if (word == "T") begin
                    cmd.a0 = test_names.size();
                    test_names.push_back(text);
                end else begin
                    cmd.a0 = (text == "zeros") ? 0 :
                             (text == "ones")  ? 1 :
                             (text == "odd")   ? 2 : -1;
                end
            end else begin
                a0 = 0;
                a1 = 0;
                a2 = 0;
                a3 = 0;
                n  = $sscanf(line, "%s %d %d %d %d", word, a0, a1, a2, a3);
                cmd.a0 = a0;
                cmd.a1 = a1;
                cmd.a2 = a2;
                cmd.a3 = a3;
            end
            cmds.push_back(cmd);
        end
        $fclose(fd);
    endtask

    function automatic longint cycle_cost(input cmd_t cmd);
        case (cmd.op)
            "X":      return 17;
            "M":      return 626;
            "C":      return 3;
            "F":      return longint'((cmd.a2 - cmd.a0 + 1) * (cmd.a3 - cmd.a1 + 1) + 3);
            "P":      return 2;
            "R", "W": return 6;
            default:  return 0;
        endcase
    endfunction

    task automatic run_command(input cmd_t cmd);
        acc_t dat;
        bit   acked;
        case (cmd.op)
            "T": begin
                close_test();
                test_name   = test_names[cmd.a0];
                test_errors = 0;
                test_open   = 1'b1;
            end
            "X": apply_reset();
            "M": load_mask(cmd.a0);
            "C": load_center_at(cmd.a0, cmd.a1);
            "F": send_frame(cmd.a0, cmd.a1, cmd.a2, cmd.a3);
            "P": send_pixel_checked(cmd.a0, cmd.a1, cmd.a2);
            "R": begin
                wb_access(1'b0, cmd.a0, dat, acked);
                if (acked) begin
                    check_acc(cmd.a0, acc_t'(cmd.a1), dat);
                end
            end
            "W": wb_access(1'b1, cmd.a0, dat, acked);
            default: note_failure($sformatf("unknown command %c in stimulus file", cmd.op));
        endcase
    endtask

    initial begin
        longint total;
        s_axi_aresetn  = 1'b0;
        pixel_in       = '0;
        load_center    = 1'b0;
        load_contour   = 1'b0;
        contour_data   = 1'b0;
        wb_req         = '0;
        watchdog_armed = 1'b0;
        test_name      = "";
        test_open      = 1'b0;
        test_errors    = 0;
        tests_passed   = 0;
        tests_failed   = 0;
        setup_errors   = 0;
        total          = 0;
        read_commands();
        foreach (cmds[i]) begin
            total += cycle_cost(cmds[i]);
        end
        watchdog_ns    = (2 * total + 1000) * 100;
        watchdog_armed = 1'b1;
        repeat (16) @(negedge s_axi_aclk);
        s_axi_aresetn = 1'b1;
        foreach (cmds[i]) begin
            run_command(cmds[i]);
        end
        close_test();
        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && setup_errors == 0 && tests_passed > 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- tb/tracer_assertions.sv
`timescale 1ns/1ns

module tracer_assertions import tracer_pkg::*; (
    input logic    s_axi_aclk,
    input logic    s_axi_aresetn,
    input wb_req_t wb_req,
    input wb_rsp_t wb_rsp,
    input pixel_t  pixel_out
);

    // Classic acknowledge is a single pulse
    ack_single_cycle: assert property (
        @(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        wb_rsp.ack |=> !wb_rsp.ack
    ) else $error("Wishbone ack held for more than one cycle");

    ack_after_request: assert property (
        @(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb)
    ) else $error("Wishbone ack without a preceding cyc and stb");

    stream_idle_in_reset: assert property (
        @(posedge s_axi_aclk)
        !s_axi_aresetn |-> !pixel_out.valid
    ) else $error("pixel_out valid while in reset");

endmodule

bind tracer_element_core tracer_assertions tracer_assertions_inst (
    .s_axi_aclk    (s_axi_aclk),
    .s_axi_aresetn (s_axi_aresetn),
    .wb_req        (wb_req),
    .wb_rsp        (wb_rsp),
    .pixel_out     (pixel_out)
);

//--- tb/tracer_input.txt
# Commands: T name, X, M ones|zeros|odd, C row col, F r0 c0 r1 c1,
# P row col data, R adr expected, W adr. Frame data is (row + 2*col) mod 256
T reset_readback
R 0 0
R 1 0
R 2 0
R 3 0
R 4 0
R 5 0
R 6 0
R 7 0
W 3
R 3 0
T pixel_passthrough
P 250 500 17
P 255 511 255
P 240 480 170
T full_window
# Element 0 window rows 28..52, cols 48..72
M ones
C 40 60
F 26 46 54 74
R 0 34464
R 1 0
T overlap_odd_zero
M odd
C 100 40
M zeros
C 105 45
F 85 25 120 60
R 0 34464
R 1 56160
R 2 0
T selector_wrap
M ones
C 220 300
M ones
C 220 340
M ones
C 220 380
M ones
C 220 420
M ones
C 220 460
# Ninth load goes to element 0, which keeps its old sum
M odd
C 150 30
F 136 16 164 44
R 0 34448
R 1 56160
R 2 0
R 3 0
R 7 0
T reset_midrun
X
R 0 0
R 1 0
R 6 0
M ones
C 40 60
F 26 46 54 74
R 0 34464
R 1 0

//--- verilog.f
verilog/tracer_pkg.sv
verilog/tracer_sequencer.sv
verilog/trace_element.sv
verilog/trace_readout_wb.sv
verilog/tracer_element_core.sv
tb/tracer_assertions.sv
tb/tb_tracer.sv

//--- verilog/trace_element.sv
`timescale 1ns/1ns

module trace_element import tracer_pkg::*; (
    input  logic                   s_axi_aclk,
    input  logic                   s_axi_aresetn,

    input  pixel_t                 stage_pixel,
    input  logic                   center_we,
    input  logic                   mask_we,
    input  logic [MASK_ADDR_W-1:0] mask_wr_addr,
    input  logic                   mask_wr_bit,

    output acc_t                   acc
);

    center_t                center;
    logic [ROW_W-1:0]       row_dist;
    logic [COL_W-1:0]       col_dist;
    logic                   in_window;

    logic                   mask_mem [WINDOW_AREA];
    logic [MASK_ADDR_W-1:0] rd_ptr;
    logic                   mask_q;

    logic                   hit_q;
    logic [PIX_W-1:0]       data_q;
    acc_t                   acc_q;

    //////////////////////////////////////////////////
    // Window test
    //////////////////////////////////////////////////

    assign row_dist = (stage_pixel.row > center.row) ? (stage_pixel.row - center.row)
                                                     : (center.row - stage_pixel.row);
    assign col_dist = (stage_pixel.col > center.col) ? (stage_pixel.col - center.col)
                                                     : (center.col - stage_pixel.col);

    assign in_window = stage_pixel.valid
                    && (row_dist <= ROW_W'(TRACE_RADIUS))
                    && (col_dist <= COL_W'(TRACE_RADIUS));

    //////////////////////////////////////////////////
    // Mask memory with one bit per window position
    //////////////////////////////////////////////////

    always_ff @(posedge s_axi_aclk) begin
        if (mask_we) begin
            mask_mem[mask_wr_addr] <= mask_wr_bit;
        end
        mask_q <= mask_mem[rd_ptr];
        data_q <= stage_pixel.data;
    end

    // Raster order within the window
    always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
        if (!s_axi_aresetn) begin
            rd_ptr <= '0;
        end else if (in_window) begin
            if (rd_ptr == MASK_ADDR_W'(WINDOW_AREA - 1)) begin
                rd_ptr <= '0;
            end else begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Centre and accumulator
    //////////////////////////////////////////////////

    always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
        if (!s_axi_aresetn) begin
            center <= '0;
            hit_q  <= 1'b0;
            acc_q  <= '0;
        end else begin
            if (center_we) begin
                center.row <= stage_pixel.row;
                center.col <= stage_pixel.col;
            end
            hit_q <= in_window;
            // Wraps at 16 bits
            if (hit_q && mask_q) begin
                acc_q <= acc_q + ACC_W'(data_q);
            end
        end
    end

    assign acc = acc_q;

endmodule

//--- verilog/trace_readout_wb.sv
`timescale 1ns/1ns

module trace_readout_wb import tracer_pkg::*; (
    input  logic    s_axi_aclk,
    input  logic    s_axi_aresetn,

    input  wb_req_t wb_req,
    input  acc_t    acc [NUM_ELEMENTS],

    output wb_rsp_t wb_rsp
);

    logic ack_q;
    acc_t dat_q;
    logic req_new;

    // New cycle only while no ack is pending
    assign req_new = wb_req.cyc && wb_req.stb && !ack_q;

    //////////////////////////////////////////////////
    // Single cycle acknowledge
    //////////////////////////////////////////////////

    always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
        if (!s_axi_aresetn) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req_new;
        end
    end

    // Read data sampled with the request; writes leave it alone
    always_ff @(posedge s_axi_aclk) begin
        if (req_new && !wb_req.we) begin
            dat_q <= acc[wb_req.adr];
        end
    end

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = dat_q;

endmodule

//--- verilog/tracer_element_core.sv
`timescale 1ns/1ns

module tracer_element_core import tracer_pkg::*; (
    input  logic    s_axi_aclk,
    input  logic    s_axi_aresetn,

    input  pixel_t  pixel_in,
    output pixel_t  pixel_out,

    input  logic    load_center,
    input  logic    load_contour,
    input  logic    contour_data,

    input  wb_req_t wb_req,
    output wb_rsp_t wb_rsp
);

    pixel_t                  stage_pixel;
    logic [NUM_ELEMENTS-1:0] center_we;
    logic [NUM_ELEMENTS-1:0] mask_we;
    logic [MASK_ADDR_W-1:0]  mask_wr_addr;
    logic                    mask_wr_bit;
    acc_t                    acc [NUM_ELEMENTS];

    //////////////////////////////////////////////////
    // Front end
    //////////////////////////////////////////////////

    tracer_sequencer tracer_sequencer_inst (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .pixel_in      (pixel_in),
        .load_center   (load_center),
        .load_contour  (load_contour),
        .contour_data  (contour_data),
        .stage_pixel   (stage_pixel),
        .center_we     (center_we),
        .mask_we       (mask_we),
        .mask_wr_addr  (mask_wr_addr),
        .mask_wr_bit   (mask_wr_bit)
    );

    // Next stage sees the same staged beat
    assign pixel_out = stage_pixel;

    //////////////////////////////////////////////////
    // Elements
    //////////////////////////////////////////////////

    for (genvar i = 0; i < NUM_ELEMENTS; i++) begin : g_element
        trace_element trace_element_inst (
            .s_axi_aclk    (s_axi_aclk),
            .s_axi_aresetn (s_axi_aresetn),
            .stage_pixel   (stage_pixel),
            .center_we     (center_we[i]),
            .mask_we       (mask_we[i]),
            .mask_wr_addr  (mask_wr_addr),
            .mask_wr_bit   (mask_wr_bit),
            .acc           (acc[i])
        );
    end

    trace_readout_wb trace_readout_wb_inst (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .wb_req        (wb_req),
        .acc           (acc),
        .wb_rsp        (wb_rsp)
    );

endmodule

//--- verilog/tracer_pkg.sv
package tracer_pkg;

    //////////////////////////////////////////////////
    // Geometry
    //////////////////////////////////////////////////

    localparam int ROW_W        = 8;
    localparam int COL_W        = 9;
    localparam int PIX_W        = 8;
    localparam int ACC_W        = 16;

    localparam int NUM_ELEMENTS = 8;
    localparam int SEL_W        = 3;

    // Window is (2*TRACE_RADIUS+1) square
    localparam int TRACE_RADIUS = 12;
    localparam int WINDOW_AREA  = 625;
    localparam int MASK_ADDR_W  = 10;

    //////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////

    typedef struct packed {
        logic             valid;
        logic [ROW_W-1:0] row;
        logic [COL_W-1:0] col;
        logic [PIX_W-1:0] data;
    } pixel_t;

    typedef struct packed {
        logic [ROW_W-1:0] row;
        logic [COL_W-1:0] col;
    } center_t;

    typedef logic [ACC_W-1:0] acc_t;

    // Wishbone classic bus word addressed by element index
    typedef struct packed {
        logic             cyc;
        logic             stb;
        logic             we;
        logic [SEL_W-1:0] adr;
    } wb_req_t;

    typedef struct packed {
        logic ack;
        acc_t dat;
    } wb_rsp_t;

endpackage

//--- verilog/tracer_sequencer.sv
`timescale 1ns/1ns

module tracer_sequencer import tracer_pkg::*; (
    input  logic                    s_axi_aclk,
    input  logic                    s_axi_aresetn,

    input  pixel_t                  pixel_in,
    input  logic                    load_center,
    input  logic                    load_contour,
    input  logic                    contour_data,

    output pixel_t                  stage_pixel,
    output logic [NUM_ELEMENTS-1:0] center_we,
    output logic [NUM_ELEMENTS-1:0] mask_we,
    output logic [MASK_ADDR_W-1:0]  mask_wr_addr,
    output logic                    mask_wr_bit
);

    logic                    load_center_reg;
    logic                    load_center_end;
    logic [SEL_W-1:0]        load_sel;
    logic [MASK_ADDR_W-1:0]  wr_ptr;
    logic [NUM_ELEMENTS-1:0] sel_onehot;

    //////////////////////////////////////////////////
    // Pixel stage
    //////////////////////////////////////////////////

    always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
        if (!s_axi_aresetn) begin
            stage_pixel <= '0;
        end else begin
            stage_pixel <= pixel_in;
        end
    end

    //////////////////////////////////////////////////
    // Centre load and element select
    //////////////////////////////////////////////////

    // Falling edge of load_center closes a centre load
    assign load_center_end = load_center_reg && !load_center;

    always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
        if (!s_axi_aresetn) begin
            load_center_reg <= 1'b0;
            load_sel        <= '0;
        end else begin
            load_center_reg <= load_center;
            if (load_center_end) begin
                if (load_sel == SEL_W'(NUM_ELEMENTS - 1)) begin
                    load_sel <= '0;
                end else begin
                    load_sel <= load_sel + 1'b1;
                end
            end
        end
    end

    // Contour write pointer shared by all elements
    always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
        if (!s_axi_aresetn) begin
            wr_ptr <= '0;
        end else if (load_contour) begin
            if (wr_ptr == MASK_ADDR_W'(WINDOW_AREA - 1)) begin
                wr_ptr <= '0;
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    assign sel_onehot   = NUM_ELEMENTS'(1) << load_sel;
    assign center_we    = load_center_end ? sel_onehot : '0;
    assign mask_we      = load_contour ? sel_onehot : '0;
    assign mask_wr_addr = wr_ptr;
    assign mask_wr_bit  = contour_data;

endmodule
